/* Bender.yml */
package:
  name: usb_interface

export_include_dirs:
  - logic

sources:
  - files:
      - logic/adc_iface_pkg.sv
      - logic/host_cmd_rx.sv
      - logic/adc_reg_bank.sv
      - logic/host_reply_tx.sv
      - logic/usb_interface.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/tb_usb_interface.sv

/* dv/tb_usb_interface.sv */
`timescale 1ns/100ps
`include "adc_iface_macros.svh"

module tb_usb_interface
	import adc_iface_pkg::*;
();

	localparam int WAIT_LIMIT = 2000; // Cycles allowed per wait loop

	logic  ftdi_clk = 1'b0;
	logic  reset = 1'b1;
	logic  cmdfifo_rxf_i = 1'b0;
	logic  cmdfifo_txe_i = 1'b1;
	byte_t cmdfifo_din_i = '0;
	logic  fifo_empty_i = 1'b1;
	byte_t fifo_data_i = '0;
	byte_t status_i = '0;
	word_t extclk_frequency_i = '0;
	word_t maxsamples_i = 32'h0001_E240; // Loaded into the sample count by reset

	logic  cmdfifo_rd_o;
	logic  cmdfifo_wr_o;
	byte_t cmdfifo_dout_o;
	logic  cmdfifo_isout_o;
	logic  fifo_rd_en_o;
	byte_t gain_o;
	logic  hilow_o;
	logic  trigger_mode_o;
	logic  cmd_arm_o;
	logic  trigger_wait_o;
	logic  adc_clk_src_o;
	word_t maxsamples_o;

	byte_t  host_q[$];  // Bytes waiting at the host
	byte_t  adc_q[$];   // ADC FIFO contents
	byte_t  rx_log[$];  // Every byte the host took
	byte_t  exp_log[$];
	int     errors = 0;
	int     timeouts = 0;
	int     bad_pops = 0;
	int     isout_falls = 0; // One per finished read reply
	int     reads_queued = 0;
	logic   isout_prev = 1'b0;
	logic   txe_random = 1'b0; // Back-pressure on the reply path
	integer seed = 32'h5e8b07d0;

	usb_interface usb_interface_i (.*);

	initial begin
		forever #10 ftdi_clk = ~ftdi_clk;
	end

	// Host FTDI side and ADC FIFO models
	always @(posedge ftdi_clk) begin : host_model
		byte_t  fifo_next;
		logic   popped;
		integer rnd;
		popped = 1'b0;
		if (cmdfifo_rd_o) begin
			if (host_q.size() == 0) begin
				errors++;
				$display("host byte read while the host queue was empty at %0t", $time);
			end else
				void'(host_q.pop_front()); // Host pops on the edge ending rd
		end
		if (cmdfifo_wr_o) begin
			rx_log.push_back(cmdfifo_dout_o);
			if (!cmdfifo_txe_i) begin
				errors++;
				$display("host byte written while txe was low at %0t", $time);
			end
		end
		if (fifo_rd_en_o) begin
			if (adc_q.size() == 0) begin
				bad_pops++;
				errors++;
				$display("ADC FIFO read while empty at %0t", $time);
			end else begin
				fifo_next = adc_q.pop_front();
				popped    = 1'b1;
			end
		end
		if (isout_prev && !cmdfifo_isout_o) isout_falls++;
		isout_prev = cmdfifo_isout_o;
		#2;
		cmdfifo_rxf_i = (host_q.size() != 0);
		cmdfifo_din_i = (host_q.size() != 0) ? host_q[0] : '0;
		fifo_empty_i  = (adc_q.size() == 0);
		if (popped) fifo_data_i = fifo_next; // Valid the cycle after rd_en
		if (txe_random) begin
			rnd           = $random(seed);
			cmdfifo_txe_i = rnd[0];
		end else
			cmdfifo_txe_i = 1'b1;
	end

	function automatic byte_t write_cmd(input reg_addr_t addr);
		byte_t c;
		c = {2'b00, addr};
		c[`CMD_VALID_BIT] = 1'b1;
		c[`CMD_WRITE_BIT] = 1'b1;
		return c;
	endfunction

	function automatic byte_t read_cmd(input reg_addr_t addr);
		byte_t c;
		c = {2'b00, addr};
		c[`CMD_VALID_BIT] = 1'b1; // Write bit stays clear
		return c;
	endfunction

	task automatic next_cycle();
		@(posedge ftdi_clk);
		#2;
	endtask

	task automatic queue_write(input reg_addr_t addr, input byte_t data);
		host_q.push_back(write_cmd(addr));
		host_q.push_back(data);
	endtask

	task automatic queue_read(input reg_addr_t addr);
		host_q.push_back(read_cmd(addr));
		reads_queued++; // Every read raises isout once, mapped or not
	endtask

	task automatic report_mismatch(input string sig, input word_t exp, input word_t act);
		errors++;
		$display("error: time %0t, %s expected 0x%0h, got 0x%0h", $time, sig, exp, act);
	endtask

	task automatic start_test(input string name);
		rx_log.delete();
		exp_log.delete();
		$display("running %s", name);
	endtask

	// Host drained, all read replies over, then settle
	task automatic finish_commands();
		int n;
		n = 0;
		while (host_q.size() != 0 && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (host_q.size() != 0) begin
			timeouts++;
			$display("timeout: host queue still holds %0d bytes", host_q.size());
		end
		n = 0;
		while (isout_falls < reads_queued && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (isout_falls < reads_queued) begin
			timeouts++;
			$display("timeout: %0d read replies never finished", reads_queued - isout_falls);
		end
		repeat (3) next_cycle();
	endtask

	task automatic compare_reply_log();
		if (rx_log.size() != exp_log.size())
			report_mismatch("reply byte count", exp_log.size(), rx_log.size());
		else
			foreach (exp_log[i])
				if (rx_log[i] !== exp_log[i])
					report_mismatch($sformatf("cmdfifo_dout_o byte %0d", i), exp_log[i], rx_log[i]);
	endtask

	task automatic check_reset_state();
		if (cmdfifo_rd_o !== 1'b0) report_mismatch("cmdfifo_rd_o", 0, cmdfifo_rd_o);
		if (cmdfifo_wr_o !== 1'b0) report_mismatch("cmdfifo_wr_o", 0, cmdfifo_wr_o);
		if (cmdfifo_isout_o !== 1'b0) report_mismatch("cmdfifo_isout_o", 0, cmdfifo_isout_o);
		if (fifo_rd_en_o !== 1'b0) report_mismatch("fifo_rd_en_o", 0, fifo_rd_en_o);
		if (gain_o !== 8'h00) report_mismatch("gain_o", 0, gain_o);
		if (maxsamples_o !== maxsamples_i) report_mismatch("maxsamples_o", maxsamples_i, maxsamples_o);
	endtask

	task automatic reg_readback(input byte_t gain, input byte_t settings, input byte_t echo);
		start_test("register write and readback");
		queue_write(`GAIN_ADDR, gain);
		queue_write(`SETTINGS_ADDR, settings);
		queue_write(`ECHO_ADDR, echo);
		queue_read(`GAIN_ADDR);
		queue_read(`SETTINGS_ADDR);
		queue_read(`ECHO_ADDR);
		exp_log.push_back(gain);
		exp_log.push_back(settings);
		exp_log.push_back(echo);
		finish_commands();
		compare_reply_log();
		if (gain_o !== gain) report_mismatch("gain_o", gain, gain_o);
		if (hilow_o !== settings[`SET_HILOW_BIT])
			report_mismatch("hilow_o", settings[`SET_HILOW_BIT], hilow_o);
		if (trigger_mode_o !== settings[`SET_TRIGMODE_BIT])
			report_mismatch("trigger_mode_o", settings[`SET_TRIGMODE_BIT], trigger_mode_o);
		if (cmd_arm_o !== settings[`SET_ARM_BIT])
			report_mismatch("cmd_arm_o", settings[`SET_ARM_BIT], cmd_arm_o);
		if (trigger_wait_o !== settings[`SET_TRIGWAIT_BIT])
			report_mismatch("trigger_wait_o", settings[`SET_TRIGWAIT_BIT], trigger_wait_o);
		if (adc_clk_src_o !== settings[`SET_CLKSRC_BIT])
			report_mismatch("adc_clk_src_o", settings[`SET_CLKSRC_BIT], adc_clk_src_o);
	endtask

	task automatic sample_count_rw();
		word_t w;
		w = 32'hA5C3_1E07;
		start_test("sample count reset value and writes");
		for (int i = 0; i < 4; i++) begin
			queue_read(reg_addr_t'(`SAMPLES_ADDR0 + i));
			exp_log.push_back(maxsamples_i[8*i +: 8]); // LSB first
		end
		finish_commands();
		compare_reply_log();
		start_test("sample count writes");
		for (int i = 0; i < 4; i++)
			queue_write(reg_addr_t'(`SAMPLES_ADDR0 + i), w[8*i +: 8]);
		for (int i = 0; i < 4; i++) begin
			queue_read(reg_addr_t'(`SAMPLES_ADDR0 + i));
			exp_log.push_back(w[8*i +: 8]);
		end
		finish_commands();
		compare_reply_log();
		if (maxsamples_o !== w) report_mismatch("maxsamples_o", w, maxsamples_o);
	endtask

	task automatic status_and_misc();
		start_test("status, unmapped read, invalid byte");
		status_i = 8'h96;
		queue_read(`STATUS_ADDR);
		exp_log.push_back(8'h96);
		queue_read(6'h0C);        // Unmapped, no reply byte
		host_q.push_back(8'h44);  // Bit 7 clear, dropped
		queue_write(`ECHO_ADDR, 8'h71);
		queue_read(`ECHO_ADDR);
		exp_log.push_back(8'h71);
		finish_commands();
		compare_reply_log();
	endtask

	task automatic freq_lock_check();
		word_t old_f;
		word_t new_f;
		old_f = 32'h1234_5678;
		new_f = 32'h9ABC_DEF0;
		start_test("frequency snapshot lock");
		extclk_frequency_i = old_f;
		next_cycle();
		queue_read(`EXTFREQ_ADDR0); // Locks the snapshot
		finish_commands();
		extclk_frequency_i = new_f;
		for (int i = 1; i < 4; i++)
			queue_read(reg_addr_t'(`EXTFREQ_ADDR0 + i));
		for (int i = 0; i < 4; i++)
			exp_log.push_back(old_f[8*i +: 8]);
		finish_commands();
		compare_reply_log();
		start_test("frequency snapshot after unlock");
		for (int i = 0; i < 4; i++) begin
			queue_read(reg_addr_t'(`EXTFREQ_ADDR0 + i));
			exp_log.push_back(new_f[8*i +: 8]);
		end
		finish_commands();
		compare_reply_log();
	endtask

	task automatic adc_dump_backpressure(input int n);
		integer rnd;
		start_test("ADC dump with random txe");
		exp_log.push_back(`ADC_SYNC_BYTE);
		for (int i = 0; i < n; i++) begin
			rnd = $random(seed);
			adc_q.push_back(rnd[7:0]);
			exp_log.push_back(rnd[7:0]);
		end
		txe_random = 1'b1;
		queue_read(`ADCDATA_ADDR);
		finish_commands();
		txe_random = 1'b0;
		compare_reply_log();
		if (adc_q.size() != 0) begin
			errors++;
			$display("ADC FIFO still holds %0d bytes after the dump", adc_q.size());
		end
	endtask

	initial begin
		repeat (5) @(posedge ftdi_clk);
		#2 reset = 1'b0;
		next_cycle();
		check_reset_state();
		reg_readback(8'h5A, 8'h6E, 8'h3C);
		if (timeouts == 0) reg_readback(8'hA5, 8'h91, 8'hC3); // Control bits back to zero
		if (timeouts == 0) sample_count_rw();
		if (timeouts == 0) status_and_misc();
		if (timeouts == 0) freq_lock_check();
		if (timeouts == 0) adc_dump_backpressure(12);
		$display("errors: %0d, timeouts: %0d, empty FIFO pops: %0d", errors, timeouts, bad_pops);
		if (errors == 0 && timeouts == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* logic/adc_iface_macros.svh */
`ifndef ADC_IFACE_MACROS_SVH
`define ADC_IFACE_MACROS_SVH

// Register map, addresses come from bits 5:0 of the command byte
`define GAIN_ADDR        6'd0   // PWM gain setting
`define SETTINGS_ADDR    6'd1   // Control bits
`define STATUS_ADDR      6'd2   // Read only
`define ADCDATA_ADDR     6'd3   // Read starts the ADC dump
`define ECHO_ADDR        6'd4   // Link check scratch byte

// External clock frequency, LSB first
`define EXTFREQ_ADDR0    6'd5
`define EXTFREQ_ADDR1    6'd6
`define EXTFREQ_ADDR2    6'd7
`define EXTFREQ_ADDR3    6'd8

// Sample count, LSB first
`define SAMPLES_ADDR0    6'd16
`define SAMPLES_ADDR1    6'd17
`define SAMPLES_ADDR2    6'd18
`define SAMPLES_ADDR3    6'd19

// Command byte bits
`define CMD_VALID_BIT    7      // Clear means drop the byte
`define CMD_WRITE_BIT    6      // Set write, clear read

// Settings register bits
`define SET_HILOW_BIT    1      // Amplifier hilo
`define SET_TRIGMODE_BIT 2      // Trigger polarity
`define SET_ARM_BIT      3
`define SET_TRIGWAIT_BIT 5      // Wait for trigger inactive before arming
`define SET_CLKSRC_BIT   6      // ADC clock source, 1 = external

`define ADC_SYNC_BYTE    8'hAC  // Leads every ADC dump

`endif

/* logic/adc_iface_pkg.sv */
package adc_iface_pkg;

	// Host bus byte, register contents, ADC FIFO data
	typedef logic [7:0] byte_t;

	// Register address from the command byte
	typedef logic [5:0] reg_addr_t;

	// Sample count and clock frequency
	typedef logic [31:0] word_t;

endpackage

/* logic/adc_reg_bank.sv */
`timescale 1ns/100ps
`include "adc_iface_macros.svh"

module adc_reg_bank
	import adc_iface_pkg::*;
(
	input  logic      ftdi_clk,
	input  logic      reset,
	input  reg_addr_t reg_addr_i,
	input  logic      reg_wr_i,
	input  byte_t     reg_wdata_i,
	input  logic      reg_rd_i,            // Register byte sent to host
	input  byte_t     status_i,
	input  word_t     extclk_frequency_i,
	input  word_t     maxsamples_i,        // Sample count after reset
	output byte_t     rd_data_o,
	output logic      rd_hit_o,
	output byte_t     gain_o,
	output logic      hilow_o,
	output logic      trigger_mode_o,
	output logic      cmd_arm_o,
	output logic      trigger_wait_o,
	output logic      adc_clk_src_o,
	output word_t     maxsamples_o
);

	byte_t gain_q;
	byte_t settings_q;
	byte_t echo_q;
	word_t samples_q;
	word_t freq_snap;     // Frequency seen by host reads
	logic  freq_locked;
	logic  lock_set;      // Low frequency byte going out now

	assign lock_set = reg_rd_i && (reg_addr_i >= `EXTFREQ_ADDR0) &&
		(reg_addr_i <= `EXTFREQ_ADDR2);

	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset) begin
			gain_q      <= '0;
			settings_q  <= '0;
			echo_q      <= '0;
			samples_q   <= maxsamples_i; // Capture as much as possible by default
			freq_locked <= 1'b0;
		end else begin
			if (reg_wr_i) begin
				case (reg_addr_i)
					`GAIN_ADDR:     gain_q          <= reg_wdata_i;
					`SETTINGS_ADDR: settings_q      <= reg_wdata_i;
					`ECHO_ADDR:     echo_q          <= reg_wdata_i;
					`SAMPLES_ADDR0: samples_q[7:0]   <= reg_wdata_i;
					`SAMPLES_ADDR1: samples_q[15:8]  <= reg_wdata_i;
					`SAMPLES_ADDR2: samples_q[23:16] <= reg_wdata_i;
					`SAMPLES_ADDR3: samples_q[31:24] <= reg_wdata_i;
					default: ; // Read only or unmapped
				endcase
			end
			if (reg_rd_i) freq_locked <= lock_set; // Any other read unlocks
		end
	end

	// Freeze while a four byte frequency read is under way
	always_ff @(posedge ftdi_clk) begin
		if (!freq_locked && !lock_set) freq_snap <= extclk_frequency_i;
	end

	always_comb begin
		rd_data_o = '0;
		rd_hit_o  = 1'b1;
		case (reg_addr_i)
			`GAIN_ADDR:     rd_data_o = gain_q;
			`SETTINGS_ADDR: rd_data_o = settings_q;
			`STATUS_ADDR:   rd_data_o = status_i;
			`ECHO_ADDR:     rd_data_o = echo_q;
			`EXTFREQ_ADDR0: rd_data_o = freq_snap[7:0];
			`EXTFREQ_ADDR1: rd_data_o = freq_snap[15:8];
			`EXTFREQ_ADDR2: rd_data_o = freq_snap[23:16];
			`EXTFREQ_ADDR3: rd_data_o = freq_snap[31:24];
			`SAMPLES_ADDR0: rd_data_o = samples_q[7:0];
			`SAMPLES_ADDR1: rd_data_o = samples_q[15:8];
			`SAMPLES_ADDR2: rd_data_o = samples_q[23:16];
			`SAMPLES_ADDR3: rd_data_o = samples_q[31:24];
			default:        rd_hit_o  = 1'b0; // ADCDATA handled by the transmitter
		endcase
	end

	assign gain_o         = gain_q;
	assign hilow_o        = settings_q[`SET_HILOW_BIT];
	assign trigger_mode_o = settings_q[`SET_TRIGMODE_BIT];
	assign cmd_arm_o      = settings_q[`SET_ARM_BIT];
	assign trigger_wait_o = settings_q[`SET_TRIGWAIT_BIT];
	assign adc_clk_src_o  = settings_q[`SET_CLKSRC_BIT];
	assign maxsamples_o   = samples_q;

	// Receiver writes and transmitter reads never overlap
	a_wr_rd_excl: assert property (@(posedge ftdi_clk) disable iff (reset)
		!(reg_wr_i && reg_rd_i));

endmodule

/* logic/host_cmd_rx.sv */
`timescale 1ns/100ps
`include "adc_iface_macros.svh"

module host_cmd_rx
	import adc_iface_pkg::*;
(
	input  logic      ftdi_clk,
	input  logic      reset,
	input  logic      cmdfifo_rxf_i,   // Host has a byte waiting
	input  byte_t     cmdfifo_din_i,
	input  logic      rd_ack_i,        // Reply finished
	output logic      cmdfifo_rd_o,    // One cycle pop strobe
	output reg_addr_t reg_addr_o,      // Held until next command
	output logic      reg_wr_o,
	output byte_t     reg_wdata_o,
	output logic      rd_req_o
);

	typedef enum logic [2:0] {
		idle,
		cmd,        // Command byte on the bus
		wr_wait,    // Waiting for the data byte
		wr_data,    // Data byte on the bus
		rd_req,     // Reply in progress
		rd_release  // Waiting for ack to drop
	} rx_state_t;

	rx_state_t state;

	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset) begin
			state        <= idle;
			cmdfifo_rd_o <= 1'b0;
			reg_wr_o     <= 1'b0;
			rd_req_o     <= 1'b0;
		end else begin
			reg_wr_o <= 1'b0; // Strobe only
			case (state)
				idle: if (cmdfifo_rxf_i) begin
					cmdfifo_rd_o <= 1'b1;
					state        <= cmd;
				end
				cmd: begin
					cmdfifo_rd_o <= 1'b0; // Byte captured on this edge
					if (!cmdfifo_din_i[`CMD_VALID_BIT])
						state <= idle; // Not a command, drop it
					else if (cmdfifo_din_i[`CMD_WRITE_BIT])
						state <= wr_wait;
					else begin
						rd_req_o <= 1'b1;
						state    <= rd_req;
					end
				end
				wr_wait: if (cmdfifo_rxf_i) begin
					cmdfifo_rd_o <= 1'b1;
					state        <= wr_data;
				end
				wr_data: begin
					cmdfifo_rd_o <= 1'b0;
					reg_wr_o     <= 1'b1; // Bank updates on next edge
					state        <= idle;
				end
				rd_req: if (rd_ack_i) begin
					rd_req_o <= 1'b0;
					state    <= rd_release;
				end
				rd_release: if (!rd_ack_i) state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// Address and data latched as the rd pulse ends
	always_ff @(posedge ftdi_clk) begin
		if (state == cmd) reg_addr_o <= cmdfifo_din_i[5:0];
		if (state == wr_data) reg_wdata_o <= cmdfifo_din_i;
	end

	// Every pop is a single cycle strobe
	a_rd_single: assert property (@(posedge ftdi_clk) disable iff (reset)
		cmdfifo_rd_o |=> !cmdfifo_rd_o);

	// Request held until the transmitter acknowledges
	a_req_hold: assert property (@(posedge ftdi_clk) disable iff (reset)
		rd_req_o && !rd_ack_i |=> rd_req_o);

endmodule

/* logic/host_reply_tx.sv */
`timescale 1ns/100ps
`include "adc_iface_macros.svh"

module host_reply_tx
	import adc_iface_pkg::*;
(
	input  logic      ftdi_clk,
	input  logic      reset,
	input  logic      rd_req_i,
	input  reg_addr_t reg_addr_i,
	input  byte_t     rd_data_i,
	input  logic      rd_hit_i,
	input  logic      cmdfifo_txe_i,    // Host can take a byte
	input  logic      fifo_empty_i,
	input  byte_t     fifo_data_i,      // Valid the cycle after rd_en
	output logic      rd_ack_o,
	output logic      reg_rd_o,
	output logic      cmdfifo_wr_o,
	output byte_t     cmdfifo_dout_o,
	output logic      cmdfifo_isout_o,  // Bus turned towards the host
	output logic      fifo_rd_en_o
);

	typedef enum logic [2:0] {
		idle,
		decide,     // Pick register, dump or miss
		send_reg,
		send_sync,
		fifo_pop,
		fifo_load,  // FIFO data valid
		send_fifo,
		ack
	} tx_state_t;

	tx_state_t state;
	logic      sending;   // Byte waiting for txe

	assign sending = (state == send_reg) || (state == send_sync) ||
		(state == send_fifo);
	assign cmdfifo_wr_o = sending && cmdfifo_txe_i;
	assign reg_rd_o     = (state == send_reg) && cmdfifo_txe_i;
	assign fifo_rd_en_o = (state == fifo_pop); // Empty checked before entering

	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset) begin
			state           <= idle;
			rd_ack_o        <= 1'b0;
			cmdfifo_isout_o <= 1'b0;
		end else begin
			case (state)
				idle: if (rd_req_i) begin
					cmdfifo_isout_o <= 1'b1;
					state           <= decide;
				end
				decide: begin
					if (reg_addr_i == `ADCDATA_ADDR)
						state <= send_sync;
					else if (rd_hit_i)
						state <= send_reg;
					else begin
						cmdfifo_isout_o <= 1'b0; // Unmapped, nothing to send
						rd_ack_o        <= 1'b1;
						state           <= ack;
					end
				end
				send_reg: if (cmdfifo_txe_i) begin
					cmdfifo_isout_o <= 1'b0;
					rd_ack_o        <= 1'b1;
					state           <= ack;
				end
				send_sync, send_fifo: if (cmdfifo_txe_i) begin
					if (fifo_empty_i) begin
						cmdfifo_isout_o <= 1'b0; // Dump complete
						rd_ack_o        <= 1'b1;
						state           <= ack;
					end else
						state <= fifo_pop;
				end
				fifo_pop: state <= fifo_load;
				fifo_load: state <= send_fifo;
				ack: if (!rd_req_i) begin
					rd_ack_o <= 1'b0;
					state    <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	// Output byte held stable while txe is low
	always_ff @(posedge ftdi_clk) begin
		if (state == decide)
			cmdfifo_dout_o <= (reg_addr_i == `ADCDATA_ADDR) ? `ADC_SYNC_BYTE : rd_data_i;
		else if (state == fifo_load)
			cmdfifo_dout_o <= fifo_data_i;
	end

	a_wr_legal: assert property (@(posedge ftdi_clk) disable iff (reset)
		cmdfifo_wr_o |-> cmdfifo_txe_i && cmdfifo_isout_o);

	a_pop_legal: assert property (@(posedge ftdi_clk) disable iff (reset)
		fifo_rd_en_o |-> !fifo_empty_i);

endmodule

/* logic/usb_interface.sv */
`timescale 1ns/100ps

module usb_interface
	import adc_iface_pkg::*;
(
	input  logic  ftdi_clk,
	input  logic  reset,
	// Host byte FIFO
	input  logic  cmdfifo_rxf_i,
	input  logic  cmdfifo_txe_i,
	input  byte_t cmdfifo_din_i,
	output logic  cmdfifo_rd_o,
	output logic  cmdfifo_wr_o,
	output byte_t cmdfifo_dout_o,
	output logic  cmdfifo_isout_o,
	// ADC sample FIFO
	input  logic  fifo_empty_i,
	input  byte_t fifo_data_i,
	output logic  fifo_rd_en_o,
	// Status and measurements
	input  byte_t status_i,
	input  word_t extclk_frequency_i,
	input  word_t maxsamples_i,
	// Board control
	output byte_t gain_o,
	output logic  hilow_o,
	output logic  trigger_mode_o,
	output logic  cmd_arm_o,
	output logic  trigger_wait_o,
	output logic  adc_clk_src_o,
	output word_t maxsamples_o
);

	reg_addr_t reg_addr;
	byte_t     reg_wdata;
	byte_t     rd_data;
	logic      reg_wr;
	logic      reg_rd;
	logic      rd_hit;
	logic      rd_req;    // Receiver to transmitter handshake
	logic      rd_ack;

	host_cmd_rx cmd_rx_i (
		.ftdi_clk      (ftdi_clk),
		.reset         (reset),
		.cmdfifo_rxf_i (cmdfifo_rxf_i),
		.cmdfifo_din_i (cmdfifo_din_i),
		.rd_ack_i      (rd_ack),
		.cmdfifo_rd_o  (cmdfifo_rd_o),
		.reg_addr_o    (reg_addr),
		.reg_wr_o      (reg_wr),
		.reg_wdata_o   (reg_wdata),
		.rd_req_o      (rd_req)
	);

	adc_reg_bank reg_bank_i (
		.ftdi_clk           (ftdi_clk),
		.reset              (reset),
		.reg_addr_i         (reg_addr),
		.reg_wr_i           (reg_wr),
		.reg_wdata_i        (reg_wdata),
		.reg_rd_i           (reg_rd),
		.status_i           (status_i),
		.extclk_frequency_i (extclk_frequency_i),
		.maxsamples_i       (maxsamples_i),
		.rd_data_o          (rd_data),
		.rd_hit_o           (rd_hit),
		.gain_o             (gain_o),
		.hilow_o            (hilow_o),
		.trigger_mode_o     (trigger_mode_o),
		.cmd_arm_o          (cmd_arm_o),
		.trigger_wait_o     (trigger_wait_o),
		.adc_clk_src_o      (adc_clk_src_o),
		.maxsamples_o       (maxsamples_o)
	);

	host_reply_tx reply_tx_i (
		.ftdi_clk        (ftdi_clk),
		.reset           (reset),
		.rd_req_i        (rd_req),
		.reg_addr_i      (reg_addr),
		.rd_data_i       (rd_data),
		.rd_hit_i        (rd_hit),
		.cmdfifo_txe_i   (cmdfifo_txe_i),
		.fifo_empty_i    (fifo_empty_i),
		.fifo_data_i     (fifo_data_i),
		.rd_ack_o        (rd_ack),
		.reg_rd_o        (reg_rd),
		.cmdfifo_wr_o    (cmdfifo_wr_o),
		.cmdfifo_dout_o  (cmdfifo_dout_o),
		.cmdfifo_isout_o (cmdfifo_isout_o),
		.fifo_rd_en_o    (fifo_rd_en_o)
	);

endmodule

/* sim.f */
+incdir+logic
logic/adc_iface_pkg.sv
logic/host_cmd_rx.sv
logic/adc_reg_bank.sv
logic/host_reply_tx.sv
logic/usb_interface.sv
dv/tb_usb_interface.sv
